// ==== rtl/bram.sv ====
`timescale 1ns/1ps

module bram
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid,
  input  mem_req_t req,
  output logic     ready,
  output mem_rsp_t rsp
);

  logic [31:0] mem [BRAM_WORDS];

  logic                   accept;
  logic [BRAM_ADDR_W-1:0] idx;

  // One response per request, never while the previous one is still out
  assign accept = valid && !ready;

  // Upper address bits alias onto the array
  assign idx = req.addr[BRAM_ADDR_W+1:2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= accept;
    end
  end

  // Read returns the old word when a write hits the same cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp.rdata <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== rtl/clint.sv ====
`timescale 1ns/1ps

module clint
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rtc,
  input  logic        valid,
  input  mem_req_t    req,
  output logic        ready,
  output mem_rsp_t    rsp,
  output logic        msip,
  output logic        mtip,
  output logic [63:0] mtime
);

  logic        accept;
  logic [1:0]  rtc_sync;
  logic        rtc_prev;
  logic        rtc_tick;
  logic [63:0] mtimecmp;
  logic [31:0] rdata_next;

  assign accept = valid && !ready;

  // Two-flop synchronizer, then a registered edge pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_sync <= '0;
      rtc_prev <= 1'b0;
      rtc_tick <= 1'b0;
      mtime    <= '0;
      mtip     <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[0], rtc};
      rtc_prev <= rtc_sync[1];
      rtc_tick <= rtc_sync[1] && !rtc_prev;
      if (rtc_tick) begin
        mtime <= mtime + 64'd1;
      end
      mtip <= (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready    <= 1'b0;
      msip     <= 1'b0;
      mtimecmp <= '1;
    end else begin
      ready <= accept;
      if (accept && req.wstrb[0] && req.addr == CLINT_MSIP_OFS) begin
        msip <= req.wdata[0];
      end
      for (int i = 0; i < 4; i++) begin
        if (accept && req.wstrb[i]) begin
          if (req.addr == CLINT_MTIMECMP_OFS) begin
            mtimecmp[8*i +: 8] <= req.wdata[8*i +: 8];
          end
          if (req.addr == CLINT_MTIMECMP_OFS + 32'd4) begin
            mtimecmp[32 + 8*i +: 8] <= req.wdata[8*i +: 8];
          end
        end
      end
    end
  end

  // mtime is read-only from the bus
  always_comb begin
    case (req.addr)
      CLINT_MSIP_OFS:              rdata_next = {31'b0, msip};
      CLINT_MTIMECMP_OFS:          rdata_next = mtimecmp[31:0];
      CLINT_MTIMECMP_OFS + 32'd4:  rdata_next = mtimecmp[63:32];
      CLINT_MTIME_OFS:             rdata_next = mtime[31:0];
      CLINT_MTIME_OFS + 32'd4:     rdata_next = mtime[63:32];
      default:                     rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp.rdata <= rdata_next;
    end
  end

endmodule

// ==== rtl/mem_decoder.sv ====
`timescale 1ns/1ps

module mem_decoder
  import soc_pkg::*;
(
  input  logic     mem_valid,
  input  mem_req_t mem_req,
  output logic     mem_ready,
  output mem_rsp_t mem_rsp,

  output logic     bram_valid,
  output mem_req_t bram_req,
  input  logic     bram_ready,
  input  mem_rsp_t bram_rsp,

  output logic     print_valid,
  output mem_req_t print_req,
  input  logic     print_ready,
  input  mem_rsp_t print_rsp,

  output logic     clint_valid,
  output mem_req_t clint_req,
  input  logic     clint_ready,
  input  mem_rsp_t clint_rsp
);

  logic hit_clint;
  logic hit_print;

  assign hit_clint = (mem_req.addr >= CLINT_BASE) && (mem_req.addr < CLINT_TOP);
  assign hit_print = (mem_req.addr >= PRINT_BASE) && (mem_req.addr < PRINT_TOP);

  assign clint_valid = mem_valid && hit_clint;
  assign print_valid = mem_valid && hit_print;
  assign bram_valid  = mem_valid && !hit_clint && !hit_print;

  // Peripherals see offsets inside their own range
  always_comb begin
    bram_req       = mem_req;
    print_req      = mem_req;
    print_req.addr = mem_req.addr - PRINT_BASE;
    clint_req      = mem_req;
    clint_req.addr = mem_req.addr - CLINT_BASE;
  end

  always_comb begin
    mem_ready = 1'b1;
    if (bram_ready) begin
      mem_rsp = bram_rsp;
    end else if (print_ready) begin
      mem_rsp = print_rsp;
    end else if (clint_ready) begin
      mem_rsp = clint_rsp;
    end else begin
      mem_rsp   = '0;
      mem_ready = 1'b0;
    end
  end

endmodule

// ==== rtl/print.sv ====
`timescale 1ns/1ps

module print
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid,
  input  mem_req_t   req,
  output logic       ready,
  output mem_rsp_t   rsp,
  output logic       char_valid,
  output logic [7:0] char_data
);

  logic        accept;
  logic        char_wr;
  logic [31:0] count;

  assign accept  = valid && !ready;
  assign char_wr = accept && req.wstrb[0] && (req.addr == PRINT_CHAR_OFS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready      <= 1'b0;
      char_valid <= 1'b0;
      count      <= '0;
    end else begin
      ready      <= accept;
      char_valid <= char_wr;
      if (char_wr) begin
        count <= count + 32'd1;
      end
    end
  end

  // Character lands together with ready
  always_ff @(posedge clk) begin
    if (char_wr) begin
      char_data <= req.wdata[7:0];
    end
    if (accept) begin
      rsp.rdata <= (req.wstrb == 4'b0 && req.addr == PRINT_COUNT_OFS) ? count : '0;
    end
  end

endmodule

// ==== rtl/soc.sv ====
`timescale 1ns/1ps

module soc
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rtc,
  input  logic        mem_valid,
  input  mem_req_t    mem_req,
  output logic        mem_ready,
  output mem_rsp_t    mem_rsp,
  output logic        char_valid,
  output logic [7:0]  char_data,
  output logic        msip,
  output logic        mtip,
  output logic [63:0] mtime
);

  logic     bram_valid,  print_valid,  clint_valid;
  logic     bram_ready,  print_ready,  clint_ready;
  mem_req_t bram_req,    print_req,    clint_req;
  mem_rsp_t bram_rsp,    print_rsp,    clint_rsp;

  mem_decoder u_decoder (
    .mem_valid   (mem_valid),   .mem_req     (mem_req),
    .mem_ready   (mem_ready),   .mem_rsp     (mem_rsp),
    .bram_valid  (bram_valid),  .bram_req    (bram_req),
    .bram_ready  (bram_ready),  .bram_rsp    (bram_rsp),
    .print_valid (print_valid), .print_req   (print_req),
    .print_ready (print_ready), .print_rsp   (print_rsp),
    .clint_valid (clint_valid), .clint_req   (clint_req),
    .clint_ready (clint_ready), .clint_rsp   (clint_rsp)
  );

  bram u_bram (
    .clk   (clk),        .rst_n (rst_n),
    .valid (bram_valid), .req   (bram_req),
    .ready (bram_ready), .rsp   (bram_rsp)
  );

  print u_print (
    .clk        (clk),         .rst_n     (rst_n),
    .valid      (print_valid), .req       (print_req),
    .ready      (print_ready), .rsp       (print_rsp),
    .char_valid (char_valid),  .char_data (char_data)
  );

  clint u_clint (
    .clk   (clk),         .rst_n (rst_n),       .rtc   (rtc),
    .valid (clint_valid), .req   (clint_req),
    .ready (clint_ready), .rsp   (clint_rsp),
    .msip  (msip),        .mtip  (mtip),        .mtime (mtime)
  );

endmodule

// ==== rtl/soc_pkg.sv ====
package soc_pkg;

  // Upper bounds are exclusive
  localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [31:0] CLINT_TOP  = 32'h0201_0000;
  localparam logic [31:0] PRINT_BASE = 32'h1000_0000;
  localparam logic [31:0] PRINT_TOP  = 32'h1000_1000;

  // Print registers
  localparam logic [31:0] PRINT_CHAR_OFS  = 32'h0000_0000;
  localparam logic [31:0] PRINT_COUNT_OFS = 32'h0000_0004;

  // CLINT registers, high words sit 4 bytes above the low words
  localparam logic [31:0] CLINT_MSIP_OFS     = 32'h0000_0000;
  localparam logic [31:0] CLINT_MTIMECMP_OFS = 32'h0000_4000;
  localparam logic [31:0] CLINT_MTIME_OFS    = 32'h0000_BFF8;

  // RAM takes every address outside the peripheral ranges
  localparam int BRAM_WORDS  = 1024;
  localparam int BRAM_ADDR_W = $clog2(BRAM_WORDS);

  // Zero wstrb means read
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module soc_tb -o soc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/soc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sim.f ====
rtl/soc_pkg.sv
rtl/mem_decoder.sv
rtl/bram.sv
rtl/print.sv
rtl/clint.sv
rtl/soc.sv
tests/soc_props.sv
tests/soc_checker.sv
tests/soc_tb.sv

// ==== tests/soc_checker.sv ====
`timescale 1ns/1ps

module soc_checker
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rtc,
  input  logic        mem_valid,
  input  mem_req_t    mem_req,
  input  logic        mem_ready,
  input  mem_rsp_t    mem_rsp,
  input  logic        char_valid,
  input  logic [7:0]  char_data,
  input  logic        msip,
  input  logic        mtip,
  input  logic [63:0] mtime,
  output int          errors
);

  logic [31:0] ram_m [BRAM_WORDS];
  logic        ram_known [BRAM_WORDS];
  logic [31:0] count_m;
  logic        msip_m;
  logic [63:0] cmp_m;
  logic [63:0] mtime_prev;
  logic [63:0] rtc_edges;
  logic        rtc_prev;
  logic        ready_exp;
  logic        exp_char;
  logic        is_read;
  logic [31:0] ofs;
  logic [31:0] exp_rd;
  logic [9:0]  idx;

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      errors++;
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  initial begin
    errors = 0;
    for (int i = 0; i < BRAM_WORDS; i++) begin
      ram_known[i] = 1'b0;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_m    = '0;
      msip_m     = 1'b0;
      cmp_m      = '1;
      mtime_prev = '0;
      rtc_edges  = '0;
      rtc_prev   = 1'b0;
      ready_exp  = 1'b0;
    end else begin
      // Ready comes exactly one cycle after a fresh request
      compare("mem_ready", 64'(ready_exp), 64'(mem_ready));
      ready_exp = mem_valid && !mem_ready;

      if (rtc && !rtc_prev) begin
        rtc_edges++;
      end
      rtc_prev = rtc;
      if (mtime < mtime_prev || mtime > mtime_prev + 64'd1) begin
        errors++;
        $display("mtime stepped from %0d to %0d at %0t", mtime_prev, mtime, $time);
      end
      if (mtime > rtc_edges) begin
        errors++;
        $display("mtime %0d ahead of %0d rtc edges at %0t", mtime, rtc_edges, $time);
      end
      compare("mtip", 64'(mtime_prev >= cmp_m), 64'(mtip));

      exp_char = 1'b0;
      is_read  = (mem_req.wstrb == 4'b0);
      if (mem_valid && mem_ready) begin
        if (mem_req.addr >= CLINT_BASE && mem_req.addr < CLINT_TOP) begin
          ofs = mem_req.addr - CLINT_BASE;
          if (is_read && ofs == CLINT_MTIME_OFS) begin
            if (mem_rsp.rdata !== mtime_prev[31:0] &&
                mem_rsp.rdata !== mtime_prev[31:0] + 32'd1) begin
              errors++;
              $display("[ERROR] %0t mtime_lo expected %0h got %0h",
                       $time, mtime_prev[31:0], mem_rsp.rdata);
            end
          end else if (is_read && ofs != CLINT_MTIME_OFS + 32'd4) begin
            if (ofs == CLINT_MSIP_OFS) begin
              exp_rd = {31'b0, msip_m};
            end else if (ofs == CLINT_MTIMECMP_OFS) begin
              exp_rd = cmp_m[31:0];
            end else if (ofs == CLINT_MTIMECMP_OFS + 32'd4) begin
              exp_rd = cmp_m[63:32];
            end else begin
              exp_rd = '0;
            end
            compare("clint rdata", 64'(exp_rd), 64'(mem_rsp.rdata));
          end
          if (ofs == CLINT_MSIP_OFS && mem_req.wstrb[0]) begin
            msip_m = mem_req.wdata[0];
          end
          for (int i = 0; i < 4; i++) begin
            if (mem_req.wstrb[i] && ofs == CLINT_MTIMECMP_OFS) begin
              cmp_m[8*i +: 8] = mem_req.wdata[8*i +: 8];
            end
            if (mem_req.wstrb[i] && ofs == CLINT_MTIMECMP_OFS + 32'd4) begin
              cmp_m[32 + 8*i +: 8] = mem_req.wdata[8*i +: 8];
            end
          end
        end else if (mem_req.addr >= PRINT_BASE && mem_req.addr < PRINT_TOP) begin
          ofs = mem_req.addr - PRINT_BASE;
          if (is_read) begin
            exp_rd = (ofs == PRINT_COUNT_OFS) ? count_m : '0;
            compare("print rdata", 64'(exp_rd), 64'(mem_rsp.rdata));
          end
          if (ofs == PRINT_CHAR_OFS && mem_req.wstrb[0]) begin
            exp_char = 1'b1;
            compare("char_data", 64'(mem_req.wdata[7:0]), 64'(char_data));
            count_m++;
          end
        end else begin
          idx = mem_req.addr[11:2];
          if (is_read && ram_known[idx]) begin
            compare("bram rdata", 64'(ram_m[idx]), 64'(mem_rsp.rdata));
          end
          if (mem_req.wstrb == 4'hf) begin
            ram_known[idx] = 1'b1;
          end
          for (int i = 0; i < 4; i++) begin
            if (mem_req.wstrb[i]) begin
              ram_m[idx][8*i +: 8] = mem_req.wdata[8*i +: 8];
            end
          end
        end
        compare("msip", 64'(msip_m), 64'(msip));
      end
      compare("char_valid", 64'(exp_char), 64'(char_valid));

      mtime_prev = mtime;
    end
  end

endmodule

// ==== tests/soc_props.sv ====
`timescale 1ns/1ps

module soc_props (
  input logic clk,
  input logic rst_n,
  input logic bram_valid,
  input logic print_valid,
  input logic clint_valid,
  input logic bram_ready,
  input logic print_ready,
  input logic clint_ready
);

  // Decoder selects one target at most
  a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({bram_valid, print_valid, clint_valid}))
    else $error("more than one target valid");

  a_bram_ready: assert property (@(posedge clk) disable iff (!rst_n)
    bram_ready |-> $past(bram_valid))
    else $error("bram ready without valid");

  a_print_ready: assert property (@(posedge clk) disable iff (!rst_n)
    print_ready |-> $past(print_valid))
    else $error("print ready without valid");

  a_clint_ready: assert property (@(posedge clk) disable iff (!rst_n)
    clint_ready |-> $past(clint_valid))
    else $error("clint ready without valid");

endmodule

// Decoder has no clock, so attach where its nets and the clock meet
bind soc soc_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .bram_valid  (bram_valid),
  .print_valid (print_valid),
  .clint_valid (clint_valid),
  .bram_ready  (bram_ready),
  .print_ready (print_ready),
  .clint_ready (clint_ready)
);

// ==== tests/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb
  import soc_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        rtc;
  logic        mem_valid;
  mem_req_t    mem_req;
  logic        mem_ready;
  mem_rsp_t    mem_rsp;
  logic        char_valid;
  logic [7:0]  char_data;
  logic        msip;
  logic        mtip;
  logic [63:0] mtime;
  int          errors;
  int          tb_errors;
  int          tests_run;
  int          tests_failed;
  int          seed = 32'h691f007c;
  int          err_start;
  int          n;
  logic [31:0] rd;
  logic [31:0] addr;
  logic [31:0] alias_addr;
  logic [3:0]  wstrb;
  logic [63:0] target;

  soc uut (
    .clk        (clk),        .rst_n     (rst_n),     .rtc      (rtc),
    .mem_valid  (mem_valid),  .mem_req   (mem_req),
    .mem_ready  (mem_ready),  .mem_rsp   (mem_rsp),
    .char_valid (char_valid), .char_data (char_data),
    .msip       (msip),       .mtip      (mtip),      .mtime    (mtime)
  );

  soc_checker chk (
    .clk        (clk),        .rst_n     (rst_n),     .rtc      (rtc),
    .mem_valid  (mem_valid),  .mem_req   (mem_req),
    .mem_ready  (mem_ready),  .mem_rsp   (mem_rsp),
    .char_valid (char_valid), .char_data (char_data),
    .msip       (msip),       .mtip      (mtip),      .mtime    (mtime),
    .errors     (errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // rtc toggles every 2 to 5 cycles
  initial begin
    rtc = 1'b0;
    forever begin
      repeat (2 + ($unsigned($random(seed)) % 4)) @(negedge clk);
      rtc = ~rtc;
    end
  end

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic bus_xfer(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
                          output logic [31:0] data);
    int cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    mem_valid = 1'b1;
    mem_req   = '{addr: a, wdata: d, wstrb: s};
    while (!seen && cycles < 20) begin
      @(negedge clk);
      cycles++;
      seen = mem_ready;
    end
    if (!seen) begin
      abort_run($sformatf("no ready for request to %h", a));
    end else begin
      data = mem_rsp.rdata;
      @(negedge clk);
      mem_valid = 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (errors + tb_errors != start) begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, errors + tb_errors - start);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    mem_valid = 1'b0;
    mem_req = '0;
    tb_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    err_start = 0;
    if (mem_ready || char_valid || msip || mtip) begin
      tb_errors++;
      $display("outputs not low after reset");
    end
    finish_test("reset state", err_start);

    err_start = errors + tb_errors;
    for (int i = 0; i < 60; i++) begin
      addr = 32'h8000_0000 | ($random(seed) & 32'h0fff_fffc);
      alias_addr = 32'h8000_0000 | ($random(seed) & 32'h0fff_f000) | (addr & 32'hffc);
      bus_xfer(addr, $random(seed), 4'hf, rd);
      bus_xfer(alias_addr, $random(seed), 4'($random(seed)), rd);
      bus_xfer(addr, 32'h0, 4'h0, rd);
    end
    finish_test("bram strobes and aliasing", err_start);

    err_start = errors + tb_errors;
    for (int i = 0; i < 30; i++) begin
      wstrb = 4'($random(seed));
      bus_xfer(PRINT_BASE + PRINT_CHAR_OFS, $random(seed), wstrb, rd);
    end
    bus_xfer(PRINT_BASE + PRINT_COUNT_OFS, 32'h0, 4'h0, rd);
    finish_test("print characters and count", err_start);

    err_start = errors + tb_errors;
    for (int i = 0; i < 10; i++) begin
      bus_xfer(CLINT_BASE + CLINT_MSIP_OFS, $random(seed), 4'h1, rd);
      bus_xfer(CLINT_BASE + CLINT_MSIP_OFS, 32'h0, 4'h0, rd);
    end
    finish_test("msip", err_start);

    err_start = errors + tb_errors;
    target = mtime + 64'd2 + 64'($unsigned($random(seed)) % 4);
    bus_xfer(CLINT_BASE + CLINT_MTIMECMP_OFS, target[31:0], 4'hf, rd);
    bus_xfer(CLINT_BASE + CLINT_MTIMECMP_OFS + 32'd4, target[63:32], 4'hf, rd);
    n = 0;
    while (mtime < target && n < 400) begin
      @(negedge clk);
      n++;
    end
    if (mtime < target) begin
      tb_errors++;
      $display("mtime never reached mtimecmp");
    end else begin
      n = 0;
      while (!mtip && n < 5) begin
        @(negedge clk);
        n++;
      end
      if (!mtip) begin
        tb_errors++;
        $display("mtip did not rise after mtime passed mtimecmp");
      end
    end
    bus_xfer(CLINT_BASE + CLINT_MTIMECMP_OFS + 32'd4, 32'hffff_ffff, 4'hf, rd);
    bus_xfer(CLINT_BASE + CLINT_MTIMECMP_OFS, 32'hffff_ffff, 4'hf, rd);
    n = 0;
    while (mtip && n < 5) begin
      @(negedge clk);
      n++;
    end
    if (mtip) begin
      tb_errors++;
      $display("mtip stayed high after mtimecmp was cleared");
    end
    finish_test("mtimecmp and mtip", err_start);

    err_start = errors + tb_errors;
    for (int i = 0; i < 20; i++) begin
      bus_xfer(CLINT_BASE + CLINT_MTIME_OFS, 32'h0, 4'h0, rd);
      repeat ($unsigned($random(seed)) % 6) @(negedge clk);
    end
    finish_test("mtime reads", err_start);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             errors + tb_errors);
    if (tests_failed == 0 && errors + tb_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
